// ==== dv/tcdm_shim_checker.sv ====
// ================================================
// TCDM shim checker
// Predicts routing, addresses and read data
// ================================================
`default_nettype none

module tcdm_shim_checker (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        tcdm_req_valid_o,
  input  logic [31:0] tcdm_req_tgt_addr_o,
  input  logic        tcdm_req_wen_o,
  input  logic [31:0] tcdm_req_wdata_o,
  input  logic [3:0]  tcdm_req_amo_o,
  input  logic [3:0]  tcdm_req_be_o,
  input  logic        tcdm_req_ready_i,
  input  logic        tcdm_resp_ready_o,
  input  logic [31:0] soc_qaddr_o,
  input  logic        soc_qwrite_o,
  input  logic [3:0]  soc_qamo_o,
  input  logic [31:0] soc_qdata_o,
  input  logic [3:0]  soc_qstrb_o,
  input  logic        soc_qvalid_o,
  input  logic        soc_pready_o,
  input  logic [31:0] data_qaddr_i,
  input  logic        data_qwrite_i,
  input  logic [3:0]  data_qamo_i,
  input  logic [31:0] data_qdata_i,
  input  logic [3:0]  data_qstrb_i,
  input  logic        data_qvalid_i,
  input  logic        data_qready_o,
  input  logic [31:0] data_pdata_o,
  input  logic        data_perror_o,
  input  logic        data_pvalid_o,
  input  logic        data_pready_i,
  output int          errors_o,
  output int          pending_o
);
  import tcdm_shim_pkg::*;

  logic [31:0] ref_mem [logic [31:0]];
  logic [72:0] tcdm_exp[$];
  logic [32:0] read_exp[$];
  bit          after_reset;

  initial begin
    errors_o    = 0;
    after_reset = 1'b0;
  end

  assign pending_o = tcdm_exp.size() + read_exp.size();

  task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    errors_o++;
  endtask

  // Tile id 13:11 goes down to 8:6, field 10:6 up to 13:9
  function automatic logic [31:0] scramble(input logic [31:0] a);
    if (a < 32'd16384) return {a[31:14], a[10:6], a[13:11], a[5:0]};
    return a;
  endfunction

  always @(posedge clk_i) begin : watch
    logic [72:0] t;
    logic [32:0] r;
    logic [31:0] w;
    if (reset_i || after_reset) begin
      if (tcdm_req_valid_o || soc_qvalid_o || data_pvalid_o) begin
        report_error("valid output high in or right after reset");
      end
    end
    after_reset = reset_i;
    if (!reset_i) begin
      if (!tcdm_resp_ready_o || !soc_pready_o) begin
        report_error("response ready output low");
      end
      if (soc_qvalid_o && !(data_qvalid_i && data_qaddr_i >= TcdmEnd)) begin
        report_error("SoC request without a core request to the SoC region");
      end
      if (data_qvalid_i && data_qready_o) begin
        if (data_qaddr_i >= TcdmEnd) begin
          if (!soc_qvalid_o || soc_qaddr_o != data_qaddr_i || soc_qwrite_o != data_qwrite_i ||
              soc_qamo_o != data_qamo_i || soc_qdata_o != data_qdata_i ||
              soc_qstrb_o != data_qstrb_i) begin
            report_error($sformatf("SoC request mismatch for address %h", data_qaddr_i));
          end
        end else begin
          tcdm_exp.push_back({scramble(data_qaddr_i), data_qwrite_i, data_qamo_i,
                              data_qdata_i, data_qstrb_i});
        end
        w = ref_mem.exists(data_qaddr_i) ? ref_mem[data_qaddr_i] : '0;
        if (data_qwrite_i) begin
          for (int b = 0; b < 4; b++) begin
            if (data_qstrb_i[b]) w[8*b +: 8] = data_qdata_i[8*b +: 8];
          end
          ref_mem[data_qaddr_i] = w;
        end else begin
          if (!ref_mem.exists(data_qaddr_i)) begin
            report_error($sformatf("read of unwritten address %h", data_qaddr_i));
          end
          read_exp.push_back({data_qaddr_i > 32'h8000_0000, w});
        end
      end
      // Reads accepted and not yet delivered
      if (read_exp.size() > MaxOutstandingReads) begin
        report_error("more reads accepted than ROB slots");
      end
      if (tcdm_req_valid_o && tcdm_req_ready_i) begin
        if (tcdm_exp.size() == 0) begin
          report_error("unexpected TCDM request");
        end else begin
          t = tcdm_exp.pop_front();
          if (t != {tcdm_req_tgt_addr_o, tcdm_req_wen_o, tcdm_req_amo_o,
                    tcdm_req_wdata_o, tcdm_req_be_o}) begin
            report_error($sformatf("TCDM request addr %h, expected %h",
                                   tcdm_req_tgt_addr_o, t[72:41]));
          end
        end
      end
      if (data_pvalid_o && data_pready_i) begin
        if (read_exp.size() == 0) begin
          report_error("read response without a pending read");
        end else begin
          r = read_exp.pop_front();
          if (r != {data_perror_o, data_pdata_o}) begin
            report_error($sformatf("read data %h err %b, expected %h err %b",
                                   data_pdata_o, data_perror_o, r[31:0], r[32]));
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/tcdm_shim_tb.sv ====
// ================================================
// TCDM shim testbench
// Stimulus table, TCDM and SoC target models
// ================================================
`default_nettype none

module tcdm_shim_tb;
  import tcdm_shim_pkg::*;

  localparam int ClkPeriod   = 100;
  localparam int DriveDelay  = 10;
  localparam int WaitLimit   = 200;
  localparam int HoldRelease = 30;

  typedef struct packed {
    logic        read;
    logic        hold;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [3:0]  amo;
  } stim_t;

  logic clk_i;
  logic reset_i;
  logic tcdm_req_valid_o, tcdm_req_wen_o, tcdm_req_ready_i;
  logic tcdm_resp_valid_i, tcdm_resp_ready_o;
  logic [31:0] tcdm_req_tgt_addr_o, tcdm_req_wdata_o, tcdm_resp_rdata_i;
  logic [3:0] tcdm_req_amo_o, tcdm_req_be_o;
  logic [2:0] tcdm_req_id_o, tcdm_resp_id_i;
  logic [31:0] soc_qaddr_o, soc_qdata_o, soc_pdata_i;
  logic [3:0] soc_qamo_o, soc_qstrb_o;
  logic soc_qwrite_o, soc_qvalid_o, soc_qready_i;
  logic soc_perror_i, soc_pvalid_i, soc_pready_o;
  logic [31:0] data_qaddr_i, data_qdata_i, data_pdata_o;
  logic [3:0] data_qamo_i, data_qstrb_i;
  logic data_qwrite_i, data_qvalid_i, data_qready_o;
  logic data_perror_o, data_pvalid_o, data_pready_i;

  stim_t stim[$];
  int    check_errors;
  int    pending;
  int    timeouts;
  int    seed_val;
  bit    timed_out;

  // Target model state
  logic [31:0] tcdm_mem [logic [31:0]];
  logic [31:0] soc_mem [logic [31:0]];
  logic [31:0] tcdm_rdata [MaxOutstandingReads];
  int          tcdm_wait [MaxOutstandingReads];
  bit          tcdm_busy [MaxOutstandingReads];
  logic [32:0] soc_pend[$];

  tcdm_shim uut (.*);

  tcdm_shim_checker i_scoreboard (
    .clk_i, .reset_i,
    .tcdm_req_valid_o, .tcdm_req_tgt_addr_o, .tcdm_req_wen_o, .tcdm_req_wdata_o,
    .tcdm_req_amo_o, .tcdm_req_be_o, .tcdm_req_ready_i, .tcdm_resp_ready_o,
    .soc_qaddr_o, .soc_qwrite_o, .soc_qamo_o, .soc_qdata_o, .soc_qstrb_o,
    .soc_qvalid_o, .soc_pready_o,
    .data_qaddr_i, .data_qwrite_i, .data_qamo_i, .data_qdata_i, .data_qstrb_i,
    .data_qvalid_i, .data_qready_o, .data_pdata_o, .data_perror_o,
    .data_pvalid_o, .data_pready_i,
    .errors_o  (check_errors),
    .pending_o (pending)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  // Unwritten words read back a pattern of their address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ 32'h5a5a_a5a5;
  endfunction

  // Both target models, sampled at the edge and driven just after it
  initial begin : target_models
    logic [31:0] old_w;
    bit          found;
    tcdm_req_ready_i  = 1'b1;
    tcdm_resp_valid_i = 1'b0;
    tcdm_resp_rdata_i = '0;
    tcdm_resp_id_i    = '0;
    soc_qready_i      = 1'b1;
    soc_pdata_i       = '0;
    soc_perror_i      = 1'b0;
    soc_pvalid_i      = 1'b0;
    seed_val          = $urandom(32'h22ea_63cc);
    forever begin
      @(posedge clk_i);
      if (!reset_i && tcdm_req_valid_o && tcdm_req_ready_i) begin
        old_w = tcdm_mem.exists(tcdm_req_tgt_addr_o) ?
                tcdm_mem[tcdm_req_tgt_addr_o] : fill_word(tcdm_req_tgt_addr_o);
        if (tcdm_req_wen_o) begin
          tcdm_mem[tcdm_req_tgt_addr_o] = merge_bytes(old_w, tcdm_req_wdata_o, tcdm_req_be_o);
        end else begin
          tcdm_rdata[tcdm_req_id_o] = old_w;
          tcdm_wait[tcdm_req_id_o]  = 1 + int'($urandom % 6);
          tcdm_busy[tcdm_req_id_o]  = 1'b1;
        end
      end
      if (!reset_i && soc_qvalid_o && soc_qready_i) begin
        old_w = soc_mem.exists(soc_qaddr_o) ? soc_mem[soc_qaddr_o] : fill_word(soc_qaddr_o);
        if (soc_qwrite_o) begin
          soc_mem[soc_qaddr_o] = merge_bytes(old_w, soc_qdata_o, soc_qstrb_o);
        end else begin
          soc_pend.push_back({soc_qaddr_o > 32'h8000_0000, old_w});
        end
      end
      #DriveDelay;
      tcdm_resp_valid_i = 1'b0;
      soc_pvalid_i      = 1'b0;
      found             = 1'b0;
      for (int k = 0; k < MaxOutstandingReads; k++) begin
        if (tcdm_busy[k] && tcdm_wait[k] > 0) tcdm_wait[k]--;
        if (!found && tcdm_busy[k] && tcdm_wait[k] == 0) begin
          tcdm_resp_valid_i = 1'b1;
          tcdm_resp_rdata_i = tcdm_rdata[k];
          tcdm_resp_id_i    = 3'(k);
          tcdm_busy[k]      = 1'b0;
          found             = 1'b1;
        end
      end
      if (soc_pend.size() > 0 && ($urandom % 3) != 0) begin
        {soc_perror_i, soc_pdata_i} = soc_pend.pop_front();
        soc_pvalid_i = 1'b1;
      end
      tcdm_req_ready_i = ($urandom % 4) != 0;
      soc_qready_i     = ($urandom % 4) != 0;
    end
  end

  task automatic add_entry(input logic rd, input logic hold, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] strb,
                           input logic [3:0] amo);
    stim.push_back('{read: rd, hold: hold, addr: addr, data: data, strb: strb, amo: amo});
  endtask

  task automatic build_table();
    logic [31:0] addrs [10];
    addrs = '{32'h0000_1a44, 32'h0000_3ffc, 32'h0000_0804, 32'h0000_2000,
              32'h0000_4010, 32'h0000_fff0, 32'h0001_0000, 32'h4000_0100,
              32'h8000_0010, 32'hc000_0004};
    for (int i = 0; i < 10; i++) begin
      add_entry(1'b0, 1'b0, addrs[i], 32'h1000_0000 * (i + 1) + addrs[i], 4'hf, AMO_NONE);
    end
    add_entry(1'b0, 1'b0, addrs[0], 32'hdead_beef, 4'b0101, AMO_ADD);
    add_entry(1'b0, 1'b0, addrs[7], 32'hcafe_f00d, 4'b1100, AMO_SWAP);
    for (int i = 9; i >= 0; i--) add_entry(1'b1, 1'b0, addrs[i], '0, 4'hf, AMO_NONE);
    // Ten reads with the core response side stalled
    for (int i = 0; i < 10; i++) add_entry(1'b1, 1'b1, addrs[i % 6], '0, 4'hf, AMO_NONE);
    for (int i = 0; i < 10; i++) add_entry(1'b1, 1'b0, addrs[(i * 3) % 10], '0, 4'hf, AMO_NONE);
  endtask

  task automatic issue_entry(input stim_t e);
    int waited;
    data_qvalid_i = 1'b1;
    data_qaddr_i  = e.addr;
    data_qwrite_i = !e.read;
    data_qdata_i  = e.data;
    data_qstrb_i  = e.strb;
    data_qamo_i   = e.amo;
    data_pready_i = !e.hold;
    waited        = 0;
    @(posedge clk_i);
    while (!data_qready_o) begin
      waited++;
      if (waited == HoldRelease && e.hold) begin
        #DriveDelay data_pready_i = 1'b1;
      end
      if (waited >= WaitLimit) begin
        $display("Timeout: core request to %h was never accepted", e.addr);
        timed_out = 1'b1;
        timeouts++;
        return;
      end
      @(posedge clk_i);
    end
    #DriveDelay data_qvalid_i = 1'b0;
  endtask

  task automatic finish_run();
    $display("Errors: %0d check, %0d timeout", check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  initial begin : main
    int waited;
    reset_i = 1'b1;
    data_qvalid_i = 1'b0;
    data_qaddr_i = '0;
    data_qwrite_i = 1'b0;
    data_qdata_i = '0;
    data_qstrb_i = '0;
    data_qamo_i = '0;
    data_pready_i = 1'b1;
    timeouts = 0;
    timed_out = 1'b0;
    build_table();
    repeat (16) @(posedge clk_i);
    #DriveDelay reset_i = 1'b0;
    for (int i = 0; i < stim.size() && !timed_out; i++) begin
      issue_entry(stim[i]);
    end
    data_pready_i = 1'b1;
    waited = 0;
    while (!timed_out && pending != 0) begin
      @(posedge clk_i);
      waited++;
      if (waited >= WaitLimit) begin
        $display("Timeout: %0d expected transfers never completed", pending);
        timed_out = 1'b1;
        timeouts++;
      end
    end
    repeat (2) @(posedge clk_i);
    finish_run();
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the TCDM shim simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tcdm_shim.f --top-module tcdm_shim_tb -o sim_tcdm_shim
./obj_dir/sim_tcdm_shim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
  exit 0
fi
exit 1

// ==== source/reorder_buffer.sv ====
// ================================================
// Reorder buffer
// Returns read data to the core in request order
// ================================================
`default_nettype none

module reorder_buffer (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  id_req_i,
  output logic [tcdm_shim_pkg::RobIdWidth-1:0]  id_o,
  output logic                                  full_o,
  mem_resp_if.sink                              tcdm_resp_i,
  mem_resp_if.sink                              soc_resp_i,
  output logic [tcdm_shim_pkg::DataWidth-1:0]   data_pdata_o,
  output logic                                  data_perror_o,
  output logic                                  data_pvalid_o,
  input  logic                                  data_pready_i
);
  import tcdm_shim_pkg::*;

  logic [DataWidth-1:0]           data_q [MaxOutstandingReads];
  logic [MaxOutstandingReads-1:0] error_q;
  logic [MaxOutstandingReads-1:0] filled_q;
  logic [RobIdWidth-1:0]          alloc_ptr_q;
  logic [RobIdWidth-1:0]          read_ptr_q;
  logic [RobIdWidth:0]            count_q;
  logic                           pop;

  assign id_o   = alloc_ptr_q;
  assign full_o = (count_q == (RobIdWidth+1)'(MaxOutstandingReads));

  // Head slot leaves once its data is in
  assign data_pvalid_o = filled_q[read_ptr_q];
  assign data_pdata_o  = data_q[read_ptr_q];
  assign data_perror_o = error_q[read_ptr_q];
  assign pop           = data_pvalid_o && data_pready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      alloc_ptr_q <= '0;
      read_ptr_q  <= '0;
      count_q     <= '0;
      filled_q    <= '0;
    end else begin
      if (id_req_i) begin
        alloc_ptr_q <= alloc_ptr_q + 1'b1;
      end
      if (pop) begin
        read_ptr_q <= read_ptr_q + 1'b1;
      end
      if (id_req_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (!id_req_i && pop) begin
        count_q <= count_q - 1'b1;
      end
      // Ids of both ports never collide
      if (tcdm_resp_i.valid) begin
        filled_q[tcdm_resp_i.id] <= 1'b1;
      end
      if (soc_resp_i.valid) begin
        filled_q[soc_resp_i.id] <= 1'b1;
      end
      if (pop) begin
        filled_q[read_ptr_q] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tcdm_resp_i.valid) begin
      data_q[tcdm_resp_i.id]  <= tcdm_resp_i.data;
      error_q[tcdm_resp_i.id] <= tcdm_resp_i.error;
    end
    if (soc_resp_i.valid) begin
      data_q[soc_resp_i.id]  <= soc_resp_i.data;
      error_q[soc_resp_i.id] <= soc_resp_i.error;
    end
  end

endmodule

`default_nettype wire

// ==== source/req_router.sv ====
// ================================================
// Request router
// Scrambles sequential addresses, steers to TCDM/SoC
// ================================================
`default_nettype none

module req_router (
  mem_req_if.initiator                          tcdm_o,
  mem_req_if.initiator                          soc_o,
  input  logic                                  core_valid_i,
  input  logic [tcdm_shim_pkg::AddrWidth-1:0]   core_addr_i,
  input  logic                                  core_write_i,
  input  logic [tcdm_shim_pkg::AmoWidth-1:0]    core_amo_i,
  input  logic [tcdm_shim_pkg::DataWidth-1:0]   core_data_i,
  input  logic [tcdm_shim_pkg::StrbWidth-1:0]   core_strb_i,
  output logic                                  core_ready_o,
  input  logic [tcdm_shim_pkg::RobIdWidth-1:0]  rob_id_i,
  input  logic                                  rob_full_i,
  output logic                                  id_req_o
);
  import tcdm_shim_pkg::*;

  logic [AddrWidth-1:0] scrambled_addr;
  target_e              target;
  logic                 slot_ok;

  // Swap the tile id below the scramble field
  always_comb begin
    scrambled_addr = core_addr_i;
    if (core_addr_i < SeqRegionEnd) begin
      scrambled_addr = {core_addr_i[AddrWidth-1:TileLsb+TileIdWidth],
                        core_addr_i[BankLsb +: ScrambleWidth],
                        core_addr_i[TileLsb +: TileIdWidth],
                        core_addr_i[BankLsb-1:0]};
    end
  end

  assign target  = (core_addr_i >= TcdmEnd) ? TARGET_SOC : TARGET_TCDM;
  // Reads need a free ROB slot
  assign slot_ok = core_write_i || !rob_full_i;

  assign tcdm_o.valid = core_valid_i && slot_ok && (target == TARGET_TCDM);
  assign soc_o.valid  = core_valid_i && slot_ok && (target == TARGET_SOC);

  assign core_ready_o = slot_ok &&
                        ((target == TARGET_SOC) ? soc_o.ready : tcdm_o.ready);
  assign id_req_o     = core_valid_i && core_ready_o && !core_write_i;

  assign tcdm_o.addr  = scrambled_addr;
  assign tcdm_o.write = core_write_i;
  assign tcdm_o.amo   = amo_e'(core_amo_i);
  assign tcdm_o.data  = core_data_i;
  assign tcdm_o.strb  = core_strb_i;
  assign tcdm_o.id    = rob_id_i;

  assign soc_o.addr   = scrambled_addr;
  assign soc_o.write  = core_write_i;
  assign soc_o.amo    = amo_e'(core_amo_i);
  assign soc_o.data   = core_data_i;
  assign soc_o.strb   = core_strb_i;
  assign soc_o.id     = rob_id_i;

endmodule

`default_nettype wire

// ==== source/soc_port.sv ====
// ================================================
// SoC port
// Pass-through requests, FIFO of ROB ids for reads
// ================================================
`default_nettype none

module soc_port (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  mem_req_if.target                            req_i,
  output logic [tcdm_shim_pkg::AddrWidth-1:0]  soc_qaddr_o,
  output logic                                 soc_qwrite_o,
  output logic [tcdm_shim_pkg::AmoWidth-1:0]   soc_qamo_o,
  output logic [tcdm_shim_pkg::DataWidth-1:0]  soc_qdata_o,
  output logic [tcdm_shim_pkg::StrbWidth-1:0]  soc_qstrb_o,
  output logic                                 soc_qvalid_o,
  input  logic                                 soc_qready_i,
  input  logic [tcdm_shim_pkg::DataWidth-1:0]  soc_pdata_i,
  input  logic                                 soc_perror_i,
  input  logic                                 soc_pvalid_i,
  output logic                                 soc_pready_o,
  mem_resp_if.source                           resp_o
);
  import tcdm_shim_pkg::*;

  logic [RobIdWidth-1:0] id_fifo [MaxOutstandingReads];
  logic [RobIdWidth-1:0] wr_ptr_q;
  logic [RobIdWidth-1:0] rd_ptr_q;
  logic                  push;
  logic                  pop;

  assign soc_qvalid_o = req_i.valid;
  assign soc_qaddr_o  = req_i.addr;
  assign soc_qwrite_o = req_i.write;
  assign soc_qamo_o   = req_i.amo;
  assign soc_qdata_o  = req_i.data;
  assign soc_qstrb_o  = req_i.strb;
  assign req_i.ready  = soc_qready_i;

  // ROB limits outstanding reads, so no overflow check
  assign push = soc_qvalid_o && soc_qready_i && !soc_qwrite_o;
  assign pop  = soc_pvalid_i && soc_pready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      id_fifo[wr_ptr_q] <= req_i.id;
    end
  end

  assign soc_pready_o = 1'b1;
  assign resp_o.valid = soc_pvalid_i;
  assign resp_o.data  = soc_pdata_i;
  assign resp_o.id    = id_fifo[rd_ptr_q];
  assign resp_o.error = soc_perror_i;

endmodule

`default_nettype wire

// ==== source/tcdm_port.sv ====
// ================================================
// TCDM port
// One-entry request register, id-tagged responses
// ================================================
`default_nettype none

module tcdm_port (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  mem_req_if.target                             req_i,
  output logic                                  tcdm_req_valid_o,
  output logic [tcdm_shim_pkg::AddrWidth-1:0]   tcdm_req_tgt_addr_o,
  output logic                                  tcdm_req_wen_o,
  output logic [tcdm_shim_pkg::DataWidth-1:0]   tcdm_req_wdata_o,
  output logic [tcdm_shim_pkg::AmoWidth-1:0]    tcdm_req_amo_o,
  output logic [tcdm_shim_pkg::RobIdWidth-1:0]  tcdm_req_id_o,
  output logic [tcdm_shim_pkg::StrbWidth-1:0]   tcdm_req_be_o,
  input  logic                                  tcdm_req_ready_i,
  input  logic                                  tcdm_resp_valid_i,
  output logic                                  tcdm_resp_ready_o,
  input  logic [tcdm_shim_pkg::DataWidth-1:0]   tcdm_resp_rdata_i,
  input  logic [tcdm_shim_pkg::RobIdWidth-1:0]  tcdm_resp_id_i,
  mem_resp_if.source                            resp_o
);
  import tcdm_shim_pkg::*;

  logic                  slot_valid_q;
  logic [AddrWidth-1:0]  addr_q;
  logic                  write_q;
  amo_e                  amo_q;
  logic [DataWidth-1:0]  data_q;
  logic [StrbWidth-1:0]  strb_q;
  logic [RobIdWidth-1:0] id_q;

  // Free, or emptying this cycle
  assign req_i.ready = !slot_valid_q || tcdm_req_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      slot_valid_q <= 1'b0;
    end else if (req_i.ready) begin
      slot_valid_q <= req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid && req_i.ready) begin
      addr_q  <= req_i.addr;
      write_q <= req_i.write;
      amo_q   <= req_i.amo;
      data_q  <= req_i.data;
      strb_q  <= req_i.strb;
      id_q    <= req_i.id;
    end
  end

  assign tcdm_req_valid_o    = slot_valid_q;
  assign tcdm_req_tgt_addr_o = addr_q;
  assign tcdm_req_wen_o      = write_q;
  assign tcdm_req_wdata_o    = data_q;
  assign tcdm_req_amo_o      = amo_q;
  assign tcdm_req_id_o       = id_q;
  assign tcdm_req_be_o       = strb_q;

  // Responses go straight to the ROB
  assign tcdm_resp_ready_o = 1'b1;
  assign resp_o.valid      = tcdm_resp_valid_i;
  assign resp_o.data       = tcdm_resp_rdata_i;
  assign resp_o.id         = tcdm_resp_id_i;
  assign resp_o.error      = 1'b0;

endmodule

`default_nettype wire

// ==== source/tcdm_shim.sv ====
// ================================================
// TCDM shim top level
// Core load/store port to TCDM and SoC targets
// ================================================
`default_nettype none

module tcdm_shim (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  // TCDM
  output logic                                  tcdm_req_valid_o,
  output logic [tcdm_shim_pkg::AddrWidth-1:0]   tcdm_req_tgt_addr_o,
  output logic                                  tcdm_req_wen_o,
  output logic [tcdm_shim_pkg::DataWidth-1:0]   tcdm_req_wdata_o,
  output logic [tcdm_shim_pkg::AmoWidth-1:0]    tcdm_req_amo_o,
  output logic [tcdm_shim_pkg::RobIdWidth-1:0]  tcdm_req_id_o,
  output logic [tcdm_shim_pkg::StrbWidth-1:0]   tcdm_req_be_o,
  input  logic                                  tcdm_req_ready_i,
  input  logic                                  tcdm_resp_valid_i,
  output logic                                  tcdm_resp_ready_o,
  input  logic [tcdm_shim_pkg::DataWidth-1:0]   tcdm_resp_rdata_i,
  input  logic [tcdm_shim_pkg::RobIdWidth-1:0]  tcdm_resp_id_i,
  // SoC
  output logic [tcdm_shim_pkg::AddrWidth-1:0]   soc_qaddr_o,
  output logic                                  soc_qwrite_o,
  output logic [tcdm_shim_pkg::AmoWidth-1:0]    soc_qamo_o,
  output logic [tcdm_shim_pkg::DataWidth-1:0]   soc_qdata_o,
  output logic [tcdm_shim_pkg::StrbWidth-1:0]   soc_qstrb_o,
  output logic                                  soc_qvalid_o,
  input  logic                                  soc_qready_i,
  input  logic [tcdm_shim_pkg::DataWidth-1:0]   soc_pdata_i,
  input  logic                                  soc_perror_i,
  input  logic                                  soc_pvalid_i,
  output logic                                  soc_pready_o,
  // Core
  input  logic [tcdm_shim_pkg::AddrWidth-1:0]   data_qaddr_i,
  input  logic                                  data_qwrite_i,
  input  logic [tcdm_shim_pkg::AmoWidth-1:0]    data_qamo_i,
  input  logic [tcdm_shim_pkg::DataWidth-1:0]   data_qdata_i,
  input  logic [tcdm_shim_pkg::StrbWidth-1:0]   data_qstrb_i,
  input  logic                                  data_qvalid_i,
  output logic                                  data_qready_o,
  output logic [tcdm_shim_pkg::DataWidth-1:0]   data_pdata_o,
  output logic                                  data_perror_o,
  output logic                                  data_pvalid_o,
  input  logic                                  data_pready_i
);
  import tcdm_shim_pkg::*;

  logic [RobIdWidth-1:0] rob_id;
  logic                  rob_full;
  logic                  id_req;

  mem_req_if  tcdm_req ();
  mem_req_if  soc_req ();
  mem_resp_if tcdm_resp ();
  mem_resp_if soc_resp ();

  req_router i_req_router (
    .tcdm_o       (tcdm_req),
    .soc_o        (soc_req),
    .core_valid_i (data_qvalid_i),
    .core_addr_i  (data_qaddr_i),
    .core_write_i (data_qwrite_i),
    .core_amo_i   (data_qamo_i),
    .core_data_i  (data_qdata_i),
    .core_strb_i  (data_qstrb_i),
    .core_ready_o (data_qready_o),
    .rob_id_i     (rob_id),
    .rob_full_i   (rob_full),
    .id_req_o     (id_req)
  );

  tcdm_port i_tcdm_port (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .req_i               (tcdm_req),
    .tcdm_req_valid_o    (tcdm_req_valid_o),
    .tcdm_req_tgt_addr_o (tcdm_req_tgt_addr_o),
    .tcdm_req_wen_o      (tcdm_req_wen_o),
    .tcdm_req_wdata_o    (tcdm_req_wdata_o),
    .tcdm_req_amo_o      (tcdm_req_amo_o),
    .tcdm_req_id_o       (tcdm_req_id_o),
    .tcdm_req_be_o       (tcdm_req_be_o),
    .tcdm_req_ready_i    (tcdm_req_ready_i),
    .tcdm_resp_valid_i   (tcdm_resp_valid_i),
    .tcdm_resp_ready_o   (tcdm_resp_ready_o),
    .tcdm_resp_rdata_i   (tcdm_resp_rdata_i),
    .tcdm_resp_id_i      (tcdm_resp_id_i),
    .resp_o              (tcdm_resp)
  );

  soc_port i_soc_port (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (soc_req),
    .soc_qaddr_o  (soc_qaddr_o),
    .soc_qwrite_o (soc_qwrite_o),
    .soc_qamo_o   (soc_qamo_o),
    .soc_qdata_o  (soc_qdata_o),
    .soc_qstrb_o  (soc_qstrb_o),
    .soc_qvalid_o (soc_qvalid_o),
    .soc_qready_i (soc_qready_i),
    .soc_pdata_i  (soc_pdata_i),
    .soc_perror_i (soc_perror_i),
    .soc_pvalid_i (soc_pvalid_i),
    .soc_pready_o (soc_pready_o),
    .resp_o       (soc_resp)
  );

  reorder_buffer i_reorder_buffer (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .id_req_i      (id_req),
    .id_o          (rob_id),
    .full_o        (rob_full),
    .tcdm_resp_i   (tcdm_resp),
    .soc_resp_i    (soc_resp),
    .data_pdata_o  (data_pdata_o),
    .data_perror_o (data_perror_o),
    .data_pvalid_o (data_pvalid_o),
    .data_pready_i (data_pready_i)
  );

endmodule

`default_nettype wire

// ==== source/tcdm_shim_if.sv ====
// ================================================
// Memory request and response interfaces
// ================================================
`default_nettype none

interface mem_req_if;
  import tcdm_shim_pkg::*;

  logic                  valid;
  logic                  ready;
  logic [AddrWidth-1:0]  addr;
  logic                  write;
  amo_e                  amo;
  logic [DataWidth-1:0]  data;
  logic [StrbWidth-1:0]  strb;
  logic [RobIdWidth-1:0] id;

  modport initiator (
    output valid, addr, write, amo, data, strb, id,
    input  ready
  );

  modport target (
    input  valid, addr, write, amo, data, strb, id,
    output ready
  );
endinterface

// No ready, the ROB slot is reserved at request time
interface mem_resp_if;
  import tcdm_shim_pkg::*;

  logic                  valid;
  logic [DataWidth-1:0]  data;
  logic [RobIdWidth-1:0] id;
  logic                  error;

  modport source (
    output valid, data, id, error
  );

  modport sink (
    input valid, data, id, error
  );
endinterface

`default_nettype wire

// ==== source/tcdm_shim_pkg.sv ====
// ================================================
// TCDM shim package
// Widths, memory map constants and shared enums
// ================================================
`default_nettype none

package tcdm_shim_pkg;

  localparam int unsigned AddrWidth           = 32;
  localparam int unsigned DataWidth           = 32;
  localparam int unsigned StrbWidth           = 4;
  localparam int unsigned AmoWidth            = 4;
  localparam int unsigned MaxOutstandingReads = 8;
  localparam int unsigned RobIdWidth          = 3;

  // Memory map
  localparam int unsigned ByteOffset        = 2;
  localparam int unsigned NumBanksPerTile   = 16;
  localparam int unsigned NumTiles          = 8;
  localparam int unsigned SeqMemSizePerTile = 2048;
  localparam int unsigned TcdmEnd           = 65536;

  // Scramble fields, derived
  localparam int unsigned BankLsb       = ByteOffset + $clog2(NumBanksPerTile);
  localparam int unsigned TileLsb       = $clog2(SeqMemSizePerTile);
  localparam int unsigned TileIdWidth   = $clog2(NumTiles);
  localparam int unsigned ScrambleWidth = TileLsb - BankLsb;
  localparam int unsigned SeqRegionEnd  = SeqMemSizePerTile * NumTiles;

  typedef enum logic {
    TARGET_TCDM = 1'b0,
    TARGET_SOC  = 1'b1
  } target_e;

  typedef enum logic [AmoWidth-1:0] {
    AMO_NONE = 4'h0,
    AMO_SWAP = 4'h1,
    AMO_ADD  = 4'h2,
    AMO_AND  = 4'h3,
    AMO_OR   = 4'h4,
    AMO_XOR  = 4'h5,
    AMO_MAX  = 4'h6,
    AMO_MAXU = 4'h7,
    AMO_MIN  = 4'h8,
    AMO_MINU = 4'h9
  } amo_e;

endpackage

`default_nettype wire

// ==== tcdm_shim.f ====
source/tcdm_shim_pkg.sv
source/tcdm_shim_if.sv
source/req_router.sv
source/tcdm_port.sv
source/soc_port.sv
source/reorder_buffer.sv
source/tcdm_shim.sv
dv/tcdm_shim_checker.sv
dv/tcdm_shim_tb.sv
